/* logic/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Instructions per fetch bundle, 2 and 8 work as well
`define LANES 4

// Architectural GPR count
`define REG_COUNT 32

// Reset value for data words and targets
`define ZERO_WORD 32'h0000_0000

`endif

/* logic/cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

	// Data path widths
	typedef logic [31:0] Word_t;     // GPR operand
	typedef logic [31:0] InstAddr_t; // Byte address of an instruction
	typedef logic [31:0] Inst_t;     // Raw MIPS instruction word
	typedef logic [4:0]  RegAddr_t;  // rs / rt / rd field
	typedef logic        Bit_t;

	// One bit per lane, lane 0 is the oldest instruction
	typedef logic [`LANES-1:0] LaneMask_t;

	// Redirect selector FSM
	typedef enum logic {
		SEL_NORMAL,       // Looking for the first branch of a bundle
		SEL_SLOT_PENDING  // Last-lane branch taken, slot comes with next bundle
	} redirect_state_t;

endpackage

/* logic/lane_if.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

// One issue lane after operand fetch
interface lane_if;

	cpu_pkg::Bit_t      valid; // Bundle present in this lane
	cpu_pkg::InstAddr_t pc;    // PC of this lane's instruction
	cpu_pkg::Inst_t     inst;
	cpu_pkg::Word_t     reg1;  // Value of rs
	cpu_pkg::Word_t     reg2;  // Value of rt

	// Fetch stage side
	modport source (output valid, pc, inst, reg1, reg2);

	// Consumer side
	modport sink (input valid, pc, inst, reg1, reg2);

endinterface

/* logic/operand_fetch.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module operand_fetch (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::Bit_t      bundle_valid, // Level, one bundle per cycle
	input  cpu_pkg::InstAddr_t bundle_pc,    // PC of lane 0
	input  cpu_pkg::Inst_t     bundle_inst [`LANES],
	input  cpu_pkg::Bit_t      wr_en,
	input  cpu_pkg::RegAddr_t  wr_addr,
	input  cpu_pkg::Word_t     wr_data,
	lane_if.source             lanes [`LANES]
);

	cpu_pkg::Word_t regs [`REG_COUNT]; // GPR array, entry 0 is never written

	// Write port, $zero stays zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < `REG_COUNT; r++) begin
				regs[r] <= `ZERO_WORD;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	for (genvar i = 0; i < `LANES; i++) begin : g_lane
		cpu_pkg::RegAddr_t  rs;      // Source register fields
		cpu_pkg::RegAddr_t  rt;
		cpu_pkg::Word_t     op1;     // Operands after bypass
		cpu_pkg::Word_t     op2;
		cpu_pkg::InstAddr_t lane_pc;

		assign rs      = bundle_inst[i][25:21];
		assign rt      = bundle_inst[i][20:16];
		assign lane_pc = bundle_pc + (cpu_pkg::InstAddr_t'(i) << 2); // Word step per lane

		// Read ports with write-through so a same-cycle write is visible
		always_comb begin
			op1 = regs[rs];
			if (wr_en && (wr_addr == rs)) begin
				op1 = wr_data;
			end
			if (rs == '0) begin
				op1 = `ZERO_WORD; // Hardwired zero wins over the bypass
			end
		end

		always_comb begin
			op2 = regs[rt];
			if (wr_en && (wr_addr == rt)) begin
				op2 = wr_data;
			end
			if (rt == '0) begin
				op2 = `ZERO_WORD;
			end
		end

		// Lane valid follows the strobe every cycle
		always_ff @(posedge clk) begin
			if (rst) begin
				lanes[i].valid <= 1'b0;
			end else begin
				lanes[i].valid <= bundle_valid;
			end
		end

		// Payload only loads on a real bundle
		always_ff @(posedge clk) begin
			if (bundle_valid) begin
				lanes[i].pc   <= lane_pc;
				lanes[i].inst <= bundle_inst[i];
				lanes[i].reg1 <= op1;
				lanes[i].reg2 <= op2;
			end
		end
	end

	// Fetch never hands over a misaligned bundle
	a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
		bundle_valid |-> (bundle_pc[1:0] == 2'b00))
		else $error("operand_fetch: bundle_pc %h not word aligned", bundle_pc);

endmodule

/* logic/branch.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module branch (
	input  logic               rst,
	input  cpu_pkg::InstAddr_t pc,
	input  cpu_pkg::Inst_t     inst,
	input  cpu_pkg::Word_t     reg1, // rs value
	input  cpu_pkg::Word_t     reg2, // rt value

	output cpu_pkg::Bit_t      is_branch,
	output cpu_pkg::Bit_t      jump,
	output cpu_pkg::InstAddr_t jump_to
);

	// Primary opcodes handled here
	localparam logic [5:0] op_special = 6'b000000;
	localparam logic [5:0] op_regimm  = 6'b000001;
	localparam logic [5:0] op_j       = 6'b000010;
	localparam logic [5:0] op_jal     = 6'b000011;
	localparam logic [5:0] op_beq     = 6'b000100;
	localparam logic [5:0] op_bne     = 6'b000101;
	localparam logic [5:0] op_blez    = 6'b000110;
	localparam logic [5:0] op_bgtz    = 6'b000111;

	logic [5:0]  opcode;
	logic [25:0] instr_index; // J-type index
	logic [15:0] offset;      // I-type branch offset

	cpu_pkg::InstAddr_t pc_plus4;
	cpu_pkg::InstAddr_t target_i; // PC-relative target
	cpu_pkg::InstAddr_t target_j; // Region target
	cpu_pkg::Bit_t      cmp_equal;

	assign opcode      = inst[31:26];
	assign instr_index = inst[25:0];
	assign offset      = inst[15:0];

	assign pc_plus4 = pc + 32'd4;                                     // Delay slot PC
	assign target_i = pc_plus4 + {{14{offset[15]}}, offset, 2'b00};
	assign target_j = {pc_plus4[31:28], instr_index, 2'b00};          // 256 MB region of slot

	// BEQ and BNE compare rs with rt while BLEZ and BGTZ compare rs with zero
	assign cmp_equal = opcode[1] ? (reg1 == `ZERO_WORD) : (reg1 == reg2);

	always_comb begin
		is_branch = 1'b0;
		jump      = 1'b0;
		jump_to   = `ZERO_WORD;
		case (opcode)
			op_special: begin
				// JR and JALR differ only in funct bit 0
				is_branch = (inst[5:1] == 5'b00100);
				jump      = is_branch;
				jump_to   = reg1; // Raw register value that may be unaligned
			end
			op_regimm: begin
				// BLTZ, BGEZ, BLTZAL, BGEZAL
				is_branch = (inst[19:17] == 3'b000);
				jump      = (reg1[31] ^ inst[16]) & is_branch; // Bit 16 flips the sign test
				jump_to   = target_i;
			end
			op_beq, op_bne, op_blez, op_bgtz: begin
				is_branch = 1'b1;
				// Opcode bit 1 adds less-than and bit 0 inverts the sense
				jump      = ((reg1[31] & opcode[1]) | cmp_equal) ^ opcode[0];
				jump_to   = target_i;
			end
			op_j, op_jal: begin
				is_branch = 1'b1;
				jump      = 1'b1; // Unconditional
				jump_to   = target_j;
			end
			default: begin
				is_branch = 1'b0; // Not a control transfer
			end
		endcase
	end

endmodule

/* logic/redirect_select.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module redirect_select (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::LaneMask_t lane_valid,
	input  cpu_pkg::LaneMask_t is_branch,
	input  cpu_pkg::LaneMask_t jump,
	input  cpu_pkg::InstAddr_t jump_to [`LANES],

	output cpu_pkg::Bit_t      out_valid,   // One pulse per resolved bundle
	output cpu_pkg::LaneMask_t kill_mask,   // Younger lanes to squash
	output cpu_pkg::Bit_t      redirect,
	output cpu_pkg::InstAddr_t redirect_pc
);

	localparam int idx_w = $clog2(`LANES);

	cpu_pkg::redirect_state_t state;
	cpu_pkg::redirect_state_t state_nxt;
	cpu_pkg::InstAddr_t       pend_pc;     // Target waiting on its delay slot
	cpu_pkg::InstAddr_t       pend_pc_nxt;
	cpu_pkg::LaneMask_t       hit;
	logic                     found;
	logic [idx_w-1:0]         first;       // Oldest lane holding a branch
	cpu_pkg::Bit_t            fire;
	cpu_pkg::InstAddr_t       fire_pc;
	cpu_pkg::LaneMask_t       kill;

	assign hit = lane_valid & is_branch;

	// Priority encoder scanning down so the lowest lane ends up in first
	always_comb begin
		found = 1'b0;
		first = '0;
		for (int l = `LANES - 1; l >= 0; l--) begin
			if (hit[l]) begin
				found = 1'b1;
				first = idx_w'(l);
			end
		end
	end

	always_comb begin
		state_nxt   = state;
		pend_pc_nxt = pend_pc;
		fire        = 1'b0;
		fire_pc     = pend_pc;
		kill        = '0;
		case (state)
			cpu_pkg::SEL_NORMAL: begin
				// Later branches are shadowed by the first one
				if (found && jump[first]) begin
					if (int'(first) == `LANES - 1) begin
						// Slot lives in the next bundle
						state_nxt   = cpu_pkg::SEL_SLOT_PENDING;
						pend_pc_nxt = jump_to[first];
					end else begin
						fire    = 1'b1;
						fire_pc = jump_to[first];
						for (int l = 0; l < `LANES; l++) begin
							kill[l] = (l > int'(first) + 1); // Keep the slot at first+1
						end
					end
				end
			end
			cpu_pkg::SEL_SLOT_PENDING: begin
				// Idle cycles just wait here
				if (lane_valid[0]) begin
					fire      = 1'b1;                        // Lane 0 is the slot
					kill      = ~cpu_pkg::LaneMask_t'(1);    // Everything after it
					state_nxt = cpu_pkg::SEL_NORMAL;
				end
			end
			default: begin
				state_nxt = cpu_pkg::SEL_NORMAL;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= cpu_pkg::SEL_NORMAL;
			out_valid <= 1'b0;
			redirect  <= 1'b0;
			kill_mask <= '0;
		end else begin
			state     <= state_nxt;
			out_valid <= lane_valid[0];
			redirect  <= fire;
			kill_mask <= kill;
		end
	end

	// Stored and issued redirect targets
	always_ff @(posedge clk) begin
		pend_pc <= pend_pc_nxt;
		if (fire) begin
			redirect_pc <= fire_pc;
		end
	end

	a_redirect_in_bundle: assert property (@(posedge clk) disable iff (rst)
		redirect |-> out_valid)
		else $error("redirect_select: redirect outside a resolved bundle");

endmodule

/* logic/branch_resolve_top.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module branch_resolve_top (
	input  logic               clk,
	input  logic               rst,

	// Fetch side
	input  cpu_pkg::Bit_t      bundle_valid,
	input  cpu_pkg::InstAddr_t bundle_pc,
	input  cpu_pkg::Inst_t     bundle_inst [`LANES],

	// GPR write port
	input  cpu_pkg::Bit_t      wr_en,
	input  cpu_pkg::RegAddr_t  wr_addr,
	input  cpu_pkg::Word_t     wr_data,

	// Resolution result, two cycles after the bundle
	output cpu_pkg::Bit_t      out_valid,
	output cpu_pkg::LaneMask_t kill_mask,
	output cpu_pkg::Bit_t      redirect,
	output cpu_pkg::InstAddr_t redirect_pc
);

	lane_if lanes [`LANES] (); // One per issue slot

	cpu_pkg::LaneMask_t lane_valid;
	cpu_pkg::LaneMask_t is_branch;
	cpu_pkg::LaneMask_t jump;
	cpu_pkg::InstAddr_t jump_to [`LANES];

	// Register read and bundle staging
	operand_fetch u_fetch (
		.clk          (clk),
		.rst          (rst),
		.bundle_valid (bundle_valid),
		.bundle_pc    (bundle_pc),
		.bundle_inst  (bundle_inst),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.lanes        (lanes)
	);

	// Same combinational resolver in every lane
	for (genvar i = 0; i < `LANES; i++) begin : g_lane
		assign lane_valid[i] = lanes[i].valid;

		branch u_branch (
			.rst       (rst),
			.pc        (lanes[i].pc),
			.inst      (lanes[i].inst),
			.reg1      (lanes[i].reg1),
			.reg2      (lanes[i].reg2),
			.is_branch (is_branch[i]),
			.jump      (jump[i]),
			.jump_to   (jump_to[i])
		);
	end

	// First branch wins, registered result
	redirect_select u_select (
		.clk         (clk),
		.rst         (rst),
		.lane_valid  (lane_valid),
		.is_branch   (is_branch),
		.jump        (jump),
		.jump_to     (jump_to),
		.out_valid   (out_valid),
		.kill_mask   (kill_mask),
		.redirect    (redirect),
		.redirect_pc (redirect_pc)
	);

endmodule

/* sim/tb_branch_resolve.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_branch_resolve;

	localparam int num_cycles  = 3000;
	localparam int drain_limit = 16;
	localparam int exp_w       = 34 + `LANES; // {valid, redirect, kill, pc}

	logic               clk;
	logic               rst;
	cpu_pkg::Bit_t      bundle_valid;
	cpu_pkg::InstAddr_t bundle_pc;
	cpu_pkg::Inst_t     bundle_inst [`LANES];
	cpu_pkg::Bit_t      wr_en;
	cpu_pkg::RegAddr_t  wr_addr;
	cpu_pkg::Word_t     wr_data;
	cpu_pkg::Bit_t      out_valid;
	cpu_pkg::LaneMask_t kill_mask;
	cpu_pkg::Bit_t      redirect;
	cpu_pkg::InstAddr_t redirect_pc;

	cpu_pkg::Word_t     shadow [`REG_COUNT]; // Model GPRs
	cpu_pkg::Inst_t     next_inst [`LANES];  // Bundle for the next drive
	cpu_pkg::Bit_t      pending;             // Model waits for a delay slot
	cpu_pkg::InstAddr_t pending_pc;
	logic [exp_w-1:0]   expect_q [$];        // One entry per driven cycle
	logic [31:0]        lfsr;
	int                 errors;
	int                 checks;
	int                 outstanding;         // Valid bundles not checked yet

	branch_resolve_top u_branch_resolve_top (
		.clk          (clk),
		.rst          (rst),
		.bundle_valid (bundle_valid),
		.bundle_pc    (bundle_pc),
		.bundle_inst  (bundle_inst),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.out_valid    (out_valid),
		.kill_mask    (kill_mask),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Hard stop if the run never gets to its report
	initial begin
		#((num_cycles + 500) * 8);
		$display("Simulation timed out before the final report");
		$display("Finished with errors");
		$finish;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw(input int n, output logic [31:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]}; // One step per bit
		end
	endtask

	task automatic check_bit(input cpu_pkg::Bit_t got, input cpu_pkg::Bit_t exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_mask(input cpu_pkg::LaneMask_t got, input cpu_pkg::LaneMask_t exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input cpu_pkg::InstAddr_t got, input cpu_pkg::InstAddr_t exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Same-cycle write is visible and $zero always reads 0
	function automatic cpu_pkg::Word_t read_reg(input cpu_pkg::RegAddr_t idx,
		input cpu_pkg::Bit_t we, input cpu_pkg::RegAddr_t wa, input cpu_pkg::Word_t wd);
		if (idx == 5'd0) return '0;
		if (we && (wa == idx)) return wd;
		return shadow[idx];
	endfunction

	task automatic resolve_lane(input cpu_pkg::InstAddr_t pc, input cpu_pkg::Inst_t inst,
		input cpu_pkg::Word_t a, input cpu_pkg::Word_t b, output cpu_pkg::Bit_t br,
		output cpu_pkg::Bit_t taken, output cpu_pkg::InstAddr_t tgt);
		cpu_pkg::InstAddr_t slot_pc;
		slot_pc = pc + 32'd4;
		br      = 1'b0;
		taken   = 1'b0;
		tgt     = slot_pc + {{14{inst[15]}}, inst[15:0], 2'b00}; // PC-relative
		case (inst[31:26])
			6'd0: begin
				br    = (inst[5:0] == 6'h08) || (inst[5:0] == 6'h09); // JR, JALR
				taken = br;
				tgt   = a;
			end
			6'd1: begin
				br    = (inst[19:17] == 3'b000);
				taken = br && (inst[16] ? ($signed(a) >= 0) : ($signed(a) < 0));
			end
			6'd2, 6'd3: begin
				br    = 1'b1;
				taken = 1'b1;
				tgt   = {slot_pc[31:28], inst[25:0], 2'b00};
			end
			6'd4: begin
				br    = 1'b1;
				taken = (a == b);
			end
			6'd5: begin
				br    = 1'b1;
				taken = (a != b);
			end
			6'd6: begin
				br    = 1'b1;
				taken = ($signed(a) <= 0);
			end
			6'd7: begin
				br    = 1'b1;
				taken = ($signed(a) > 0);
			end
			default: br = 1'b0;
		endcase
	endtask

	// Selector model applied once per driven cycle
	task automatic model_cycle(input cpu_pkg::Bit_t v, input cpu_pkg::InstAddr_t pc,
		input cpu_pkg::Bit_t we, input cpu_pkg::RegAddr_t wa, input cpu_pkg::Word_t wd,
		output logic [exp_w-1:0] e);
		cpu_pkg::LaneMask_t ek;
		cpu_pkg::Bit_t      er;
		cpu_pkg::InstAddr_t ep;
		cpu_pkg::Bit_t      lb;
		cpu_pkg::Bit_t      lt;
		cpu_pkg::InstAddr_t lg;
		int                 first;
		ek    = '0;
		er    = 1'b0;
		ep    = '0;
		first = -1;
		for (int l = 0; l < `LANES; l++) begin
			resolve_lane(pc + cpu_pkg::InstAddr_t'(4 * l), next_inst[l],
				read_reg(next_inst[l][25:21], we, wa, wd),
				read_reg(next_inst[l][20:16], we, wa, wd), lb, lt, lg);
			if ((first < 0) && lb) begin
				first = l;
				er    = lt;
				ep    = lg;
			end
		end
		if (!v) begin
			er = 1'b0;
		end else if (pending) begin
			er      = 1'b1; // Lane 0 is the slot and its own branches are ignored
			ep      = pending_pc;
			ek      = '1;
			ek[0]   = 1'b0;
			pending = 1'b0;
		end else if (er && (first == `LANES - 1)) begin
			er         = 1'b0;
			pending    = 1'b1;
			pending_pc = ep;
		end else if (er) begin
			for (int l = 0; l < `LANES; l++) begin
				ek[l] = (l > first + 1); // Slot at first+1 survives
			end
		end
		if (we && (wa != 5'd0)) shadow[wa] = wd;
		e = {v, er, ek, ep};
	endtask

	task automatic check_outputs();
		logic [exp_w-1:0] e;
		while (expect_q.size() > 2) begin
			e = expect_q.pop_front();
			check_bit(out_valid, e[exp_w-1], "out_valid");
			check_bit(redirect, e[exp_w-2], "redirect");
			check_mask(kill_mask, e[32 +: `LANES], "kill_mask");
			if (e[exp_w-2]) begin
				check_addr(redirect_pc, e[31:0], "redirect_pc");
			end
			if (e[exp_w-1]) outstanding--;
		end
	endtask

	task automatic step_cycle(input cpu_pkg::Bit_t v, input cpu_pkg::InstAddr_t pc,
		input cpu_pkg::Bit_t we, input cpu_pkg::RegAddr_t wa, input cpu_pkg::Word_t wd);
		logic [exp_w-1:0] e;
		@(posedge clk);
		bundle_valid <= v;
		bundle_pc    <= pc;
		wr_en        <= we;
		wr_addr      <= wa;
		wr_data      <= wd;
		for (int l = 0; l < `LANES; l++) bundle_inst[l] <= next_inst[l];
		model_cycle(v, pc, we, wa, wd, e);
		expect_q.push_back(e);
		if (v) outstanding++;
		@(negedge clk); // Outputs settled with the result due two edges after capture
		check_outputs();
	endtask

	task automatic gen_cycle(output cpu_pkg::Bit_t v, output cpu_pkg::InstAddr_t pc,
		output cpu_pkg::Bit_t we, output cpu_pkg::RegAddr_t wa, output cpu_pkg::Word_t wd);
		logic [31:0] r;
		logic [31:0] cls;
		logic [31:0] rs;
		logic [31:0] rt;
		logic [31:0] imm;
		draw(2, r);
		v = (r[1:0] != 2'b00); // Roughly one idle cycle in four
		draw(30, r);
		pc = {r[29:0], 2'b00};
		draw(1, r);
		we = r[0];
		draw(3, r);
		wa = {2'b00, r[2:0]}; // Low registers including $zero so compares hit
		draw(2, r);
		case (r[1:0])
			2'd0: wd = '0;
			2'd1: draw(2, wd);
			2'd2: begin
				draw(31, r);
				wd = {1'b1, r[30:0]}; // Negative
			end
			default: draw(32, wd);
		endcase
		for (int l = 0; l < `LANES; l++) begin
			draw(4, cls);
			draw(3, rs);
			draw(3, rt);
			draw(16, imm);
			draw(26, r);
			case (cls[3:0])
				4'd6: next_inst[l] = {6'd4, rs[4:0], rt[4:0], imm[15:0]};
				4'd7: next_inst[l] = {6'd5, rs[4:0], rt[4:0], imm[15:0]};
				4'd8: next_inst[l] = {6'd6, rs[4:0], 5'd0, imm[15:0]};
				4'd9: next_inst[l] = {6'd7, rs[4:0], 5'd0, imm[15:0]};
				4'd10, 4'd11: next_inst[l] = {6'd1, rs[4:0], rt[1], 3'b000, rt[0], imm[15:0]};
				4'd12, 4'd13: next_inst[l] = {5'b00001, cls[0], r[25:0]}; // J, JAL
				4'd14, 4'd15: next_inst[l] = {6'd0, rs[4:0], 5'd0, {5{cls[0]}}, 5'd0, 5'b00100,
					cls[0]};
				default: next_inst[l] = {6'd9, rs[4:0], rt[4:0], imm[15:0]}; // ADDIU
			endcase
		end
	endtask

	initial begin : main
		cpu_pkg::Bit_t      v;
		cpu_pkg::InstAddr_t pc;
		cpu_pkg::Bit_t      we;
		cpu_pkg::RegAddr_t  wa;
		cpu_pkg::Word_t     wd;
		int                 waited;
		lfsr         = 32'h3a3a1cea;
		errors       = 0;
		checks       = 0;
		outstanding  = 0;
		pending      = 1'b0;
		pending_pc   = '0;
		rst          = 1'b1;
		bundle_valid = 1'b0;
		bundle_pc    = '0;
		wr_en        = 1'b0;
		wr_addr      = '0;
		wr_data      = '0;
		for (int r = 0; r < `REG_COUNT; r++) shadow[r] = '0;
		for (int l = 0; l < `LANES; l++) begin
			bundle_inst[l] = '0;
			next_inst[l]   = '0;
		end
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		for (int c = 0; c < 8; c++) step_cycle(1'b0, '0, 1'b0, '0, '0); // Quiet after reset
		for (int c = 0; c < num_cycles; c++) begin
			gen_cycle(v, pc, we, wa, wd);
			step_cycle(v, pc, we, wa, wd);
		end
		// Plain bundle so a last-lane branch still gets its slot
		for (int l = 0; l < `LANES; l++) next_inst[l] = {6'd9, 26'd0};
		step_cycle(1'b1, 32'h0000_1000, 1'b0, '0, '0);
		waited = 0;
		while ((outstanding > 0) && (waited < drain_limit)) begin
			step_cycle(1'b0, '0, 1'b0, '0, '0);
			waited++;
		end
		if (outstanding > 0) begin
			$display("Drain timed out, %0d bundles gave no result", outstanding);
			errors++;
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+logic
logic/cpu_pkg.sv
logic/lane_if.sv
logic/operand_fetch.sv
logic/branch.sv
logic/redirect_select.sv
logic/branch_resolve_top.sv
sim/tb_branch_resolve.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the branch resolve testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 -f filelist.f \
	--top-module tb_branch_resolve --Mdir "$BUILD_DIR" -o tb_branch_resolve \
	> "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_branch_resolve" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Finished with no errors" "$SIM_LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
